// File: mips_exec_pipe.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/exec_if.sv
verilog/alu.sv
verilog/decode_stage.sv
verilog/operand_stage.sv
verilog/delay_fu.sv
verilog/writeback_stage.sv
verilog/reg_file.sv
verilog/mips_exec_pipe.sv
verif/tb_mips_exec_pipe.sv

// File: Bender.yml
package:
  name: mips_exec_pipe

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mips_pkg.sv
      - verilog/exec_if.sv
      - verilog/alu.sv
      - verilog/decode_stage.sv
      - verilog/operand_stage.sv
      - verilog/delay_fu.sv
      - verilog/writeback_stage.sv
      - verilog/reg_file.sv
      - verilog/mips_exec_pipe.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_mips_exec_pipe.sv

// File: verif/tb_mips_exec_pipe.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_exec_pipe import mips_pkg::*; ();

    localparam int NUM_INSTR = 600;
    localparam int TIMEOUT   = 200; // Cycles without progress.

    logic      clk;
    logic      rst;
    logic      instr_valid;
    logic      instr_ready;
    word_t     instr_word;
    logic      retire_valid;
    logic      retire_ready;
    logic      retire_regwrite;
    reg_addr_t retire_dest;
    word_t     retire_value;
    logic      retire_hi_write;
    logic      retire_lo_write;
    logic      retire_overflow;
    logic      retire_reserved;

    logic [31:0] lfsr;
    word_t       sent_q [$];                    // Accepted, not yet retired.
    word_t       gpr [0:`MIPS_REG_COUNT-1];     // Architectural registers.
    word_t       model_hi, model_lo;
    int          sent;
    int          retired;
    logic        taking;                        // Word goes in at the next edge.

    mips_exec_pipe i_mips_exec_pipe (
        .clk, .rst,
        .instr_valid, .instr_ready, .instr_word,
        .retire_valid, .retire_ready, .retire_regwrite, .retire_dest, .retire_value,
        .retire_hi_write, .retire_lo_write, .retire_overflow, .retire_reserved
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////
    // Failure reporting and compares.
    //////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Stimulus.
    //////////////////////////////////////////////////////////////

    // 32-bit Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = '0;
        for (k = 0; k < n; k++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Opcode and funct of each drawable operation.
    function automatic logic [11:0] encoding_of(input logic [4:0] idx);
        case (idx)
            5'd0:    return {6'h00, 6'h20}; // ADD
            5'd1:    return {6'h00, 6'h21}; // ADDU
            5'd2:    return {6'h00, 6'h22}; // SUB
            5'd3:    return {6'h00, 6'h23}; // SUBU
            5'd4:    return {6'h00, 6'h24}; // AND
            5'd5:    return {6'h00, 6'h25}; // OR
            5'd6:    return {6'h00, 6'h26}; // XOR
            5'd7:    return {6'h00, 6'h27}; // NOR
            5'd8:    return {6'h00, 6'h2a}; // SLT
            5'd9:    return {6'h00, 6'h2b}; // SLTU
            5'd10:   return {6'h00, 6'h00}; // SLL
            5'd11:   return {6'h00, 6'h02}; // SRL
            5'd12:   return {6'h00, 6'h03}; // SRA
            5'd13:   return {6'h00, 6'h0a}; // MOVZ
            5'd14:   return {6'h00, 6'h0b}; // MOVN
            5'd15:   return {6'h00, 6'h10}; // MFHI
            5'd16:   return {6'h00, 6'h11}; // MTHI
            5'd17:   return {6'h00, 6'h12}; // MFLO
            5'd18:   return {6'h00, 6'h13}; // MTLO
            5'd19:   return {6'h08, 6'h00}; // ADDI
            5'd20:   return {6'h09, 6'h00}; // ADDIU
            5'd21:   return {6'h0a, 6'h00}; // SLTI
            5'd22:   return {6'h0c, 6'h00}; // ANDI
            5'd23:   return {6'h0d, 6'h00}; // ORI
            5'd24:   return {6'h0e, 6'h00}; // XORI
            5'd25:   return {6'h0f, 6'h00}; // LUI
            5'd26:   return {6'h00, 6'h3f}; // Reserved funct.
            5'd27:   return {6'h23, 6'h00}; // Load word, reserved here.
            5'd28:   return {6'h00, 6'h20}; // Extra ADD, SUB, ADDI and LUI
            5'd29:   return {6'h00, 6'h22}; // to make overflow likely.
            5'd30:   return {6'h08, 6'h00};
            default: return {6'h0f, 6'h00};
        endcase
    endfunction

    function automatic reg_addr_t random_reg();
        if (rand_bits(1) == 32'd1)
            return 5'(rand_bits(2)); // Low registers, for hazards.
        return 5'(rand_bits(5));
    endfunction

    function automatic word_t random_word();
        logic [11:0] enc;
        reg_addr_t   rs, rt, rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        enc = encoding_of(5'(rand_bits(5)));
        rs  = random_reg();
        rt  = random_reg();
        rd  = random_reg();
        sh  = 5'(rand_bits(5));
        imm = 16'(rand_bits(16));
        if (enc[11:6] == 6'h00)
            return {6'h00, rs, rt, rd, sh, enc[5:0]};
        return {enc[11:6], rs, rt, imm};
    endfunction

    //////////////////////////////////////////////////////////////
    // Architectural model.
    //////////////////////////////////////////////////////////////

    function automatic logic signed_overflow(input word_t a, input word_t b, input logic sub);
        logic [32:0] wide;
        if (sub)
            wide = {a[31], a} - {b[31], b};
        else
            wide = {a[31], a} + {b[31], b};
        return wide[32] != wide[31]; // Sign-extended result does not fit.
    endfunction

    task automatic retire_check();
        word_t      w, a, b, v, simm, zimm;
        reg_addr_t  dest;
        logic [4:0] sh;
        logic       wr, hw, lw, trap, rsv;

        if (sent_q.size() == 0)
            report_failure("An instruction retired that was never sent.");
        w    = sent_q.pop_front();
        a    = gpr[w[25:21]];
        b    = gpr[w[20:16]];
        sh   = w[10:6];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        dest = (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
        v    = '0;
        wr   = 1'b1;
        hw   = 1'b0;
        lw   = 1'b0;
        trap = 1'b0;
        rsv  = 1'b0;

        if (w[31:26] == 6'h00)
        begin
            case (w[5:0])
                6'h20:
                begin
                    v    = a + b;
                    trap = signed_overflow(a, b, 1'b0);
                end
                6'h21: v = a + b;
                6'h22:
                begin
                    v    = a - b;
                    trap = signed_overflow(a, b, 1'b1);
                end
                6'h23: v = a - b;
                6'h24: v = a & b;
                6'h25: v = a | b;
                6'h26: v = a ^ b;
                6'h27: v = ~(a | b);
                6'h2a: v = {31'b0, $signed(a) < $signed(b)};
                6'h2b: v = {31'b0, a < b};
                6'h00: v = b << sh;
                6'h02: v = b >> sh;
                6'h03: v = $signed(b) >>> sh;
                6'h0a:
                begin
                    v  = a;
                    wr = (b == '0);
                end
                6'h0b:
                begin
                    v  = a;
                    wr = (b != '0);
                end
                6'h10: v = model_hi;
                6'h12: v = model_lo;
                6'h11:
                begin
                    v  = a;
                    wr = 1'b0;
                    hw = 1'b1;
                end
                6'h13:
                begin
                    v  = a;
                    wr = 1'b0;
                    lw = 1'b1;
                end
                default: rsv = 1'b1;
            endcase
        end
        else
        begin
            case (w[31:26])
                6'h08:
                begin
                    v    = a + simm;
                    trap = signed_overflow(a, simm, 1'b0);
                end
                6'h09: v = a + simm;
                6'h0a: v = {31'b0, $signed(a) < $signed(simm)};
                6'h0c: v = a & zimm;
                6'h0d: v = a | zimm;
                6'h0e: v = a ^ zimm;
                6'h0f: v = {w[15:0], 16'h0000};
                default: rsv = 1'b1;
            endcase
        end

        if (rsv || trap)
        begin
            wr = 1'b0;
            hw = 1'b0;
            lw = 1'b0;
        end
        if (dest == '0)
            wr = 1'b0; // Register zero stays zero.

        check_flag("retire_reserved", retire_reserved, rsv);
        check_flag("retire_overflow", retire_overflow, trap);
        check_flag("retire_regwrite", retire_regwrite, wr);
        check_flag("retire_hi_write", retire_hi_write, hw);
        check_flag("retire_lo_write", retire_lo_write, lw);
        if (wr)
            check_reg("retire_dest", retire_dest, dest);
        if (wr || hw || lw)
            check_word("retire_value", retire_value, v);

        if (wr)
            gpr[dest] = v;
        if (hw)
            model_hi = v;
        if (lw)
            model_lo = v;
        retired++;
    endtask

    // Handshakes are sampled mid-cycle, where every input and output is settled.
    always @(negedge clk)
    begin
        taking = !rst && instr_valid && instr_ready;
        if (taking)
        begin
            sent_q.push_back(instr_word);
            sent++;
        end
        if (!rst && retire_valid && retire_ready)
            retire_check();
    end

    //////////////////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////////////////

    initial
    begin
        int waited;
        int edges;
        int issued;
        int last_sent;
        int r;

        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr_word   = '0;
        retire_ready = 1'b0;
        lfsr         = 32'd88049;
        sent         = 0;
        retired      = 0;
        taking       = 1'b0;
        model_hi     = '0;
        model_lo     = '0;
        for (r = 0; r < `MIPS_REG_COUNT; r++)
            gpr[r] = '0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("instr_ready", instr_ready, 1'b1);

        // Lone ADDIU r1, r0, 0x1234 on an empty pipe.
        @(posedge clk);
        instr_valid  <= 1'b1;
        instr_word   <= {6'h09, 5'd0, 5'd1, 16'h1234};
        retire_ready <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!(instr_valid && instr_ready))
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_failure("Timeout: the lone instruction was never accepted.");
        end
        @(posedge clk);            // Acceptance edge.
        instr_valid <= 1'b0;
        edges = 1;
        @(negedge clk);
        while (!retire_valid)
        begin
            @(posedge clk);
            edges++;
            if (edges > 10)
                report_failure("Timeout: the lone instruction never reached retire.");
            @(negedge clk);
        end
        if (edges != 3)
            report_failure($sformatf("Lone instruction retired after %0d edges, not 3.", edges));

        // Random stream with gaps and retire stalls.
        issued    = 1;
        last_sent = sent;
        waited    = 0;
        while (sent < NUM_INSTR)
        begin
            @(posedge clk);
            if (!instr_valid || taking)
            begin
                if (issued < NUM_INSTR && rand_bits(2) != 32'd0)
                begin
                    instr_valid <= 1'b1;
                    instr_word  <= random_word();
                    issued++;
                end
                else
                    instr_valid <= 1'b0;
            end
            retire_ready <= (rand_bits(2) != 32'd0);
            if (sent != last_sent)
            begin
                last_sent = sent;
                waited    = 0;
            end
            else
            begin
                waited++;
                if (waited > TIMEOUT)
                    report_failure("Timeout: no instruction accepted for too long.");
            end
        end

        // Drain.
        @(posedge clk);
        instr_valid  <= 1'b0;
        retire_ready <= 1'b1;
        waited = 0;
        while (retired < sent)
        begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_failure("Timeout: instructions still in the pipe after draining.");
        end

        // A drained pipe retires nothing more.
        for (r = 0; r < 8; r++)
        begin
            @(negedge clk);
            check_flag("retire_valid", retire_valid, 1'b0);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verilog/mips_exec_pipe.sv
`timescale 1ns/1ps

module mips_exec_pipe import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    output logic      instr_ready,
    input  word_t     instr_word,
    output logic      retire_valid,
    input  logic      retire_ready,
    output logic      retire_regwrite,
    output reg_addr_t retire_dest,
    output word_t     retire_value,
    output logic      retire_hi_write,
    output logic      retire_lo_write,
    output logic      retire_overflow,
    output logic      retire_reserved
);

    logic           dec_valid, dec_ready;
    decoded_instr_t dec_instr;
    logic           opnd_valid, opnd_ready;
    decoded_instr_t opnd_instr;
    word_t          opnd_srca, opnd_srcb, opnd_hi, opnd_lo;
    reg_addr_t      rd_addra, rd_addrb;
    word_t          rd_dataa, rd_datab, hi_data, lo_data;
    logic           wr_en, hi_wr_en, lo_wr_en;
    reg_addr_t      wr_addr;
    word_t          wr_data;

    exec_if ex_if ();

    //////////////////////////////////////////////////////////////
    // Pipeline stages.
    //////////////////////////////////////////////////////////////

    decode_stage i_decode_stage (
        .clk, .rst,
        .instr_valid, .instr_ready, .instr_word,
        .dec_valid, .dec_ready, .dec_instr
    );

    operand_stage i_operand_stage (
        .clk, .rst,
        .dec_valid, .dec_ready, .dec_instr,
        .rd_addra, .rd_addrb, .rd_dataa, .rd_datab, .hi_data, .lo_data,
        .wr_en, .hi_wr_en, .lo_wr_en, .wr_addr, .wr_data,
        .fwd (ex_if.fwd),
        .opnd_valid, .opnd_ready, .opnd_instr,
        .opnd_srca, .opnd_srcb, .opnd_hi, .opnd_lo
    );

    delay_fu i_delay_fu (
        .opnd_valid, .opnd_ready, .opnd_instr,
        .opnd_srca, .opnd_srcb, .opnd_hi, .opnd_lo,
        .ex (ex_if.fu)
    );

    writeback_stage i_writeback_stage (
        .clk, .rst,
        .ex (ex_if.wb),
        .retire_valid, .retire_ready, .retire_regwrite, .retire_dest, .retire_value,
        .retire_hi_write, .retire_lo_write, .retire_overflow, .retire_reserved,
        .wr_en, .wr_addr, .wr_data, .hi_wr_en, .lo_wr_en
    );

    reg_file i_reg_file (
        .clk, .rst,
        .rd_addra, .rd_addrb, .rd_dataa, .rd_datab, .hi_data, .lo_data,
        .wr_en, .wr_addr, .wr_data, .hi_wr_en, .lo_wr_en
    );

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rd_addra,
    input  reg_addr_t rd_addrb,
    output word_t     rd_dataa,
    output word_t     rd_datab,
    output word_t     hi_data,
    output word_t     lo_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  logic      hi_wr_en,
    input  logic      lo_wr_en
);

    word_t regs [1:`MIPS_REG_COUNT-1]; // No storage for register zero.
    word_t hi, lo;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < `MIPS_REG_COUNT; i++)
                regs[i] <= '0;
            hi <= '0;
            lo <= '0;
        end
        else
        begin
            if (wr_en && (wr_addr != '0))
                regs[wr_addr] <= wr_data;
            if (hi_wr_en)
                hi <= wr_data;
            if (lo_wr_en)
                lo <= wr_data;
        end
    end

    assign rd_dataa = (rd_addra == '0) ? '0 : regs[rd_addra];
    assign rd_datab = (rd_addrb == '0) ? '0 : regs[rd_addrb];
    assign hi_data  = hi;
    assign lo_data  = lo;

endmodule

// File: verilog/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    exec_if.wb        ex,
    output logic      retire_valid,
    input  logic      retire_ready,
    output logic      retire_regwrite,
    output reg_addr_t retire_dest,
    output word_t     retire_value,
    output logic      retire_hi_write,
    output logic      retire_lo_write,
    output logic      retire_overflow,
    output logic      retire_reserved,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output logic      hi_wr_en,
    output logic      lo_wr_en
);

    logic fire;

    assign ex.ready = !retire_valid || retire_ready;
    assign fire     = retire_valid && retire_ready; // Retire handshake.

    always_ff @(posedge clk)
    begin
        if (rst)
            retire_valid <= 1'b0;
        else if (ex.ready)
            retire_valid <= ex.valid;
    end

    always_ff @(posedge clk)
    begin
        if (ex.ready && ex.valid)
        begin
            retire_regwrite <= ex.regwrite;
            retire_dest     <= ex.instr.destreg;
            retire_value    <= ex.result;
            retire_hi_write <= ex.hiwrite;
            retire_lo_write <= ex.lowrite;
            retire_overflow <= ex.overflow;
            retire_reserved <= ex.reserved;
        end
    end

    // Commit only on the retire edge.
    assign wr_en    = fire && retire_regwrite;
    assign hi_wr_en = fire && retire_hi_write;
    assign lo_wr_en = fire && retire_lo_write;
    assign wr_addr  = retire_dest;
    assign wr_data  = retire_value;

endmodule

// File: verilog/delay_fu.sv
`timescale 1ns/1ps

module delay_fu import mips_pkg::*; (
    input  logic           opnd_valid,
    output logic           opnd_ready,
    input  decoded_instr_t opnd_instr,
    input  word_t          opnd_srca,
    input  word_t          opnd_srcb,
    input  word_t          opnd_hi,
    input  word_t          opnd_lo,
    exec_if.fu             ex
);

    ctl_t  ctl;
    word_t alu_a, alu_b;
    word_t alu_result;
    logic  alu_overflow;
    logic  trap;
    logic  move_ok;

    assign ctl = opnd_instr.ctl;

    //////////////////////////////////////////////////////////////
    // ALU operand select.
    //////////////////////////////////////////////////////////////

    always_comb
    begin
        if (ctl.shamt_valid)
            alu_a = word_t'(opnd_instr.shamt);
        else if (ctl.hitoreg)
            alu_a = opnd_hi;
        else if (ctl.lotoreg)
            alu_a = opnd_lo;
        else
            alu_a = opnd_srca;
    end

    assign alu_b = (ctl.alusrc == REGB) ? opnd_srcb : opnd_instr.extended_imm;

    alu i_alu (
        .srca     (alu_a),
        .srcb     (alu_b),
        .func     (ctl.alufunc),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // Conditional moves test the B operand.
    always_comb
    begin
        case (opnd_instr.op)
            OP_MOVZ: move_ok = (alu_b == '0);
            OP_MOVN: move_ok = (alu_b != '0);
            default: move_ok = 1'b1;
        endcase
    end

    assign trap = ctl.signed_of && alu_overflow;

    assign opnd_ready  = ex.ready;
    assign ex.valid    = opnd_valid;
    assign ex.instr    = opnd_instr;
    assign ex.result   = alu_result;
    assign ex.regwrite = ctl.regwrite && move_ok && !trap;
    assign ex.hiwrite  = ctl.hiwrite && !trap;
    assign ex.lowrite  = ctl.lowrite && !trap;
    assign ex.overflow = trap;
    assign ex.reserved = (opnd_instr.op == OP_RESERVED);

endmodule

// File: verilog/operand_stage.sv
`timescale 1ns/1ps

module operand_stage import mips_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           dec_valid,
    output logic           dec_ready,
    input  decoded_instr_t dec_instr,
    output reg_addr_t      rd_addra,
    output reg_addr_t      rd_addrb,
    input  word_t          rd_dataa,
    input  word_t          rd_datab,
    input  word_t          hi_data,
    input  word_t          lo_data,
    input  logic           wr_en,
    input  logic           hi_wr_en,
    input  logic           lo_wr_en,
    input  reg_addr_t      wr_addr,
    input  word_t          wr_data,
    exec_if.fwd            fwd,
    output logic           opnd_valid,
    input  logic           opnd_ready,
    output decoded_instr_t opnd_instr,
    output word_t          opnd_srca,
    output word_t          opnd_srcb,
    output word_t          opnd_hi,
    output word_t          opnd_lo
);

    word_t srca, srcb, hi, lo;

    // Taking a word only when the writeback side moves too means every older
    // result is in the register file, on the write port or on the FU output.
    assign dec_ready = opnd_ready;

    assign rd_addra = dec_instr.srcrega;
    assign rd_addrb = dec_instr.srcregb;

    //////////////////////////////////////////////////////////////
    // Forwarding, later assignments are younger producers.
    //////////////////////////////////////////////////////////////

    always_comb
    begin
        srca = rd_dataa;
        srcb = rd_datab;
        hi   = hi_data;
        lo   = lo_data;

        if (wr_en && (wr_addr == dec_instr.srcrega)) srca = wr_data;
        if (wr_en && (wr_addr == dec_instr.srcregb)) srcb = wr_data;
        if (hi_wr_en) hi = wr_data;
        if (lo_wr_en) lo = wr_data;

        if (fwd.valid && fwd.regwrite && (fwd.instr.destreg == dec_instr.srcrega))
            srca = fwd.result;
        if (fwd.valid && fwd.regwrite && (fwd.instr.destreg == dec_instr.srcregb))
            srcb = fwd.result;
        if (fwd.valid && fwd.hiwrite) hi = fwd.result;
        if (fwd.valid && fwd.lowrite) lo = fwd.result;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            opnd_valid <= 1'b0;
        else if (opnd_ready)
            opnd_valid <= dec_valid;
    end

    always_ff @(posedge clk)
    begin
        if (opnd_ready && dec_valid)
        begin
            opnd_instr <= dec_instr;
            opnd_srca  <= srca;
            opnd_srcb  <= srcb;
            opnd_hi    <= hi;
            opnd_lo    <= lo;
        end
    end

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    output logic           instr_ready,
    input  instr_word_u    instr_word,
    output logic           dec_valid,
    input  logic           dec_ready,
    output decoded_instr_t dec_instr
);

    decoded_instr_t d;
    logic           itype;

    assign instr_ready = !dec_valid || dec_ready;

    always_comb
    begin
        d         = '0;
        d.op      = OP_RESERVED;
        d.srcrega = instr_word.r.rs;
        d.srcregb = instr_word.i.rt;
        d.shamt   = instr_word.r.shamt;
        itype     = (instr_word.i.opcode != 6'h00);

        if (!itype)
        begin
            case (instr_word.r.funct)
                6'h20: d.op = OP_ADD;
                6'h21: d.op = OP_ADDU;
                6'h22: d.op = OP_SUB;
                6'h23: d.op = OP_SUBU;
                6'h24: d.op = OP_AND;
                6'h25: d.op = OP_OR;
                6'h26: d.op = OP_XOR;
                6'h27: d.op = OP_NOR;
                6'h2a: d.op = OP_SLT;
                6'h2b: d.op = OP_SLTU;
                6'h00: d.op = OP_SLL;
                6'h02: d.op = OP_SRL;
                6'h03: d.op = OP_SRA;
                6'h0a: d.op = OP_MOVZ;
                6'h0b: d.op = OP_MOVN;
                6'h10: d.op = OP_MFHI;
                6'h11: d.op = OP_MTHI;
                6'h12: d.op = OP_MFLO;
                6'h13: d.op = OP_MTLO;
                default: d.op = OP_RESERVED;
            endcase
        end
        else
        begin
            case (instr_word.i.opcode)
                6'h08: d.op = OP_ADDI;
                6'h09: d.op = OP_ADDIU;
                6'h0a: d.op = OP_SLTI;
                6'h0c: d.op = OP_ANDI;
                6'h0d: d.op = OP_ORI;
                6'h0e: d.op = OP_XORI;
                6'h0f: d.op = OP_LUI;
                default: d.op = OP_RESERVED;
            endcase
        end

        case (d.op)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU: d.ctl.alufunc = ALU_ADD;
            OP_SUB, OP_SUBU:                    d.ctl.alufunc = ALU_SUB;
            OP_AND, OP_ANDI:                    d.ctl.alufunc = ALU_AND;
            OP_OR, OP_ORI:                      d.ctl.alufunc = ALU_OR;
            OP_XOR, OP_XORI:                    d.ctl.alufunc = ALU_XOR;
            OP_NOR:                             d.ctl.alufunc = ALU_NOR;
            OP_SLT, OP_SLTI:                    d.ctl.alufunc = ALU_SLT;
            OP_SLTU:                            d.ctl.alufunc = ALU_SLTU;
            OP_SLL:                             d.ctl.alufunc = ALU_SLL;
            OP_SRL:                             d.ctl.alufunc = ALU_SRL;
            OP_SRA:                             d.ctl.alufunc = ALU_SRA;
            OP_LUI:                             d.ctl.alufunc = ALU_LUI;
            default:                            d.ctl.alufunc = ALU_PASSA; // Moves.
        endcase

        // Logical immediates and LUI are zero-extended.
        if (d.op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
            d.extended_imm = word_t'(instr_word.i.imm);
        else
            d.extended_imm = word_t'($signed(instr_word.i.imm));

        d.destreg         = itype ? instr_word.i.rt : instr_word.r.rd;
        d.ctl.alusrc      = itype ? IMM : REGB;
        d.ctl.shamt_valid = d.op inside {OP_SLL, OP_SRL, OP_SRA};
        d.ctl.hitoreg     = (d.op == OP_MFHI);
        d.ctl.lotoreg     = (d.op == OP_MFLO);
        d.ctl.hiwrite     = (d.op == OP_MTHI);
        d.ctl.lowrite     = (d.op == OP_MTLO);
        d.ctl.signed_of   = d.op inside {OP_ADD, OP_SUB, OP_ADDI};
        d.ctl.regwrite    = !(d.op inside {OP_MTHI, OP_MTLO, OP_RESERVED})
                            && (d.destreg != '0); // Register zero is never written.
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            dec_valid <= 1'b0;
        else if (instr_ready)
            dec_valid <= instr_valid;
    end

    always_ff @(posedge clk)
    begin
        if (instr_ready && instr_valid)
            dec_instr <= d;
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module alu import mips_pkg::*; (
    input  word_t    srca,
    input  word_t    srcb,
    input  alufunc_t func,
    output word_t    result,
    output logic     overflow
);

    word_t sum, diff;
    logic  sa, sb;

    assign sum  = srca + srcb;
    assign diff = srca - srcb;
    assign sa   = srca[`MIPS_WORD_WIDTH-1]; // Sign bits.
    assign sb   = srcb[`MIPS_WORD_WIDTH-1];

    always_comb
    begin
        overflow = 1'b0;
        case (func)
            ALU_ADD:
            begin
                result   = sum;
                overflow = (sa == sb) && (sum[`MIPS_WORD_WIDTH-1] != sa);
            end
            ALU_SUB:
            begin
                result   = diff;
                overflow = (sa != sb) && (diff[`MIPS_WORD_WIDTH-1] != sa);
            end
            ALU_AND:   result = srca & srcb;
            ALU_OR:    result = srca | srcb;
            ALU_XOR:   result = srca ^ srcb;
            ALU_NOR:   result = ~(srca | srcb);
            ALU_SLT:   result = word_t'($signed(srca) < $signed(srcb));
            ALU_SLTU:  result = word_t'(srca < srcb);
            ALU_SLL:   result = srcb << srca[4:0];              // Amount in A.
            ALU_SRL:   result = srcb >> srca[4:0];
            ALU_SRA:   result = word_t'($signed(srcb) >>> srca[4:0]);
            ALU_LUI:   result = {srcb[15:0], 16'h0000};
            default:   result = srca;                           // Pass A
        endcase
    end

endmodule

// File: verilog/exec_if.sv
`timescale 1ns/1ps

interface exec_if import mips_pkg::*; ();

    logic           valid;
    logic           ready;
    decoded_instr_t instr;
    word_t          result;
    logic           regwrite; // Resolved, after MOVZ/MOVN and traps.
    logic           hiwrite;
    logic           lowrite;
    logic           overflow;
    logic           reserved;

    modport fu (
        output valid, instr, result, regwrite, hiwrite, lowrite, overflow, reserved,
        input  ready
    );

    modport wb (
        input  valid, instr, result, regwrite, hiwrite, lowrite, overflow, reserved,
        output ready
    );

    // Youngest forwarding source.
    modport fwd (
        input valid, instr, regwrite, hiwrite, lowrite, result
    );

endinterface

// File: verilog/mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_WIDTH-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] reg_addr_t;

    //////////////////////////////////////////////////////////////
    // Instruction word, seen as R-type and as I-type.
    //////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rtype_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } itype_t;

    typedef union packed {
        rtype_t r;
        itype_t i;
    } instr_word_u;

    //////////////////////////////////////////////////////////////
    // Decoded instruction.
    //////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
        OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_LUI,
        OP_MOVZ, OP_MOVN, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_RESERVED
    } decoded_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASSA
    } alufunc_t;

    typedef enum logic {
        REGB,
        IMM
    } alusrc_t;

    typedef struct packed {
        alufunc_t alufunc;
        alusrc_t  alusrc;
        logic     shamt_valid; // Operand A is the shift amount.
        logic     regwrite;
        logic     hitoreg;     // Operand A is HI.
        logic     lotoreg;     // Operand A is LO.
        logic     hiwrite;
        logic     lowrite;
        logic     signed_of;   // Overflow traps.
    } ctl_t;

    typedef struct packed {
        decoded_op_t op;
        ctl_t        ctl;
        reg_addr_t   srcrega;
        reg_addr_t   srcregb;
        reg_addr_t   destreg;
        logic [4:0]  shamt;
        word_t       extended_imm;
    } decoded_instr_t;

endpackage

// File: verilog/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

//////////////////////////////////////////////////////////////
// Architectural sizes of the integer core.
//////////////////////////////////////////////////////////////

`define MIPS_WORD_WIDTH     32 // Data word.
`define MIPS_REG_COUNT      32 // General registers, zero included.
`define MIPS_REG_ADDR_WIDTH 5  // Register number.

`endif
